//--- design/kyber_params_pkg.sv
package kyber_params_pkg;

	// ****************************************
	// Kyber arithmetic.
	// ****************************************

	localparam int KYBER_Q = 3329; // Prime modulus of the ring.

	localparam int COEFF_W = 12; // Enough bits for 0 to q-1.

	localparam int LANES = 4; // Coefficients carried in one word.

	// ****************************************
	// Noise word layout.
	// ****************************************

	localparam int NOISE_W = 25;

	// The top bit picks eta 3 when set, eta 2 when clear.
	localparam int ETA_SEL_BIT = NOISE_W - 1;

	typedef logic [COEFF_W-1:0] coeff_t;

	// Lane 0 sits in the low bits.
	typedef coeff_t [LANES-1:0] poly_word_t;

	typedef logic [NOISE_W-1:0] noise_word_t;

endpackage

//--- design/noise_acc_ctrl_pkg.sv
package noise_acc_ctrl_pkg;

	localparam int WORDS_PER_POLY = 64; // Words read in each phase.

	localparam int WORD_IDX_W = $clog2(WORDS_PER_POLY);

	// Cycles to wait after the last request of a phase.
	localparam int DRAIN_CYCLES = 2;

	typedef logic [WORD_IDX_W-1:0] word_idx_t;

	typedef enum logic [2:0] {
		IDLE,
		NOISE,
		NOISE_DRAIN,
		ACC,
		ACC_DRAIN,
		DONE
	} acc_state_t;

endpackage

//--- design/noise_acc_fsm.sv
`timescale 1ns/1ps

module noise_acc_fsm
	import noise_acc_ctrl_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic start_i,
	input  logic noise_empty_i,
	input  logic poly_empty_i,
	input  logic last_i,
	output logic noise_req_o,
	output logic poly_req_o,
	output logic cnt_clr_o,
	output logic cnt_step_o,
	output logic done_o
);

	acc_state_t state;
	acc_state_t next_state;
	logic [1:0] drain_cnt;
	logic       drain_end;
	logic       start_ok;

	assign start_ok  = start_i && (state == IDLE || state == DONE);
	assign drain_end = drain_cnt == 2'(DRAIN_CYCLES - 1);

	// A request goes out only in its phase and only while data is there.
	assign noise_req_o = (state == NOISE) && !noise_empty_i;
	assign poly_req_o  = (state == ACC) && !poly_empty_i;

	assign cnt_step_o = noise_req_o || poly_req_o; // Index follows the request.
	assign cnt_clr_o  = start_ok;
	assign done_o     = state == DONE;

	// ****************************************
	// State sequencing.
	// ****************************************

	always_comb begin
		next_state = state;
		case (state)
			IDLE, DONE: begin
				if (start_ok)
					next_state = NOISE;
			end
			NOISE: begin
				if (noise_req_o && last_i)
					next_state = NOISE_DRAIN;
			end
			NOISE_DRAIN: begin
				if (drain_end)
					next_state = ACC;
			end
			ACC: begin
				if (poly_req_o && last_i)
					next_state = ACC_DRAIN;
			end
			ACC_DRAIN: begin
				if (drain_end)
					next_state = DONE;
			end
			default: next_state = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= IDLE;
			drain_cnt <= '0;
		end else begin
			state <= next_state;
			if (state == NOISE_DRAIN || state == ACC_DRAIN)
				drain_cnt <= drain_end ? 2'd0 : drain_cnt + 2'd1;
			else
				drain_cnt <= '0;
		end
	end

	// ****************************************
	// Protocol checks.
	// ****************************************

	a_req_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(noise_req_o && poly_req_o))
		else $error("Noise and polynomial requests issued together.");

	a_no_req_on_empty: assert property (@(posedge clk) disable iff (rst)
		!(noise_req_o && noise_empty_i) && !(poly_req_o && poly_empty_i))
		else $error("FIFO read requested while the FIFO is empty.");

endmodule

//--- design/word_counter.sv
`timescale 1ns/1ps

module word_counter
	import noise_acc_ctrl_pkg::*;
#(
	parameter int COUNT_MAX = WORDS_PER_POLY - 1
) (
	input  logic      clk,
	input  logic      rst,
	input  logic      clr_i,
	input  logic      step_i,
	output word_idx_t idx_o,
	output logic      last_o
);

	localparam word_idx_t IDX_MAX = WORD_IDX_W'(COUNT_MAX);

	word_idx_t idx;

	assign idx_o  = idx;
	assign last_o = idx == IDX_MAX;

	always_ff @(posedge clk) begin
		if (rst || clr_i) begin
			idx <= '0;
		end else if (step_i) begin
			// Wrap so the next phase starts at word 0 without a clear.
			idx <= last_o ? '0 : idx + 1'b1;
		end
	end

	// Clear comes from start only and steps come from the phase states.
	a_clr_step_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(clr_i && step_i))
		else $error("Counter clear and step asserted in the same cycle.");

endmodule

//--- design/cbd_sampler.sv
`timescale 1ns/1ps

module cbd_sampler
	import kyber_params_pkg::*;
	import noise_acc_ctrl_pkg::*;
(
	input  logic        clk,
	input  logic        word_valid_i,
	input  noise_word_t word_i,
	input  word_idx_t   word_idx_i,
	output poly_word_t  coeffs_o,
	output logic        wr_en_o,
	output word_idx_t   wr_idx_o
);

	// One centered-binomial sample folded into 0 to q-1.
	function automatic coeff_t cbd_lane(input noise_word_t w, input int lane);
		logic [1:0] pos_sum;
		logic [1:0] neg_sum;
		if (w[ETA_SEL_BIT]) begin
			pos_sum = 2'(w[6*lane]) + 2'(w[6*lane+1]) + 2'(w[6*lane+2]);
			neg_sum = 2'(w[6*lane+3]) + 2'(w[6*lane+4]) + 2'(w[6*lane+5]);
		end else begin
			pos_sum = 2'(w[4*lane]) + 2'(w[4*lane+1]);
			neg_sum = 2'(w[4*lane+2]) + 2'(w[4*lane+3]);
		end
		if (pos_sum >= neg_sum)
			return COEFF_W'(pos_sum - neg_sum);
		else
			return COEFF_W'(KYBER_Q) - COEFF_W'(neg_sum - pos_sum); // Negative maps to q+v.
	endfunction

	// ****************************************
	// Sample and register.
	// ****************************************

	poly_word_t coeffs_next;

	always_comb begin
		for (int n = 0; n < LANES; n++) begin
			coeffs_next[n] = cbd_lane(word_i, n);
		end
	end

	always_ff @(posedge clk) begin
		wr_en_o <= word_valid_i; // Write strobe for the RAM.
		if (word_valid_i) begin
			coeffs_o <= coeffs_next;
			wr_idx_o <= word_idx_i;
		end
	end

endmodule

//--- design/poly_ram.sv
`timescale 1ns/1ps

module poly_ram
	import kyber_params_pkg::*;
	import noise_acc_ctrl_pkg::*;
#(
	parameter int DEPTH = WORDS_PER_POLY
) (
	input  logic       clk,
	input  logic       wr_en_i,
	input  word_idx_t  wr_idx_i,
	input  poly_word_t wr_data_i,
	input  word_idx_t  rd_idx_i,
	output poly_word_t rd_data_o
);

	poly_word_t mem [DEPTH];

	// The sampler feeds the write port.
	always_ff @(posedge clk) begin
		if (wr_en_i)
			mem[wr_idx_i] <= wr_data_i;
	end

	// The read port runs every cycle. Data lines up with the delayed request.
	always_ff @(posedge clk) begin
		rd_data_o <= mem[rd_idx_i];
	end

endmodule

//--- design/mod_q_adder.sv
`timescale 1ns/1ps

module mod_q_adder
	import kyber_params_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       in_valid_i,
	input  poly_word_t a_i,
	input  poly_word_t b_i,
	output poly_word_t sum_o,
	output logic       sum_valid_o
);

	localparam logic [COEFF_W:0] Q_EXT = (COEFF_W + 1)'(KYBER_Q);

	// Both inputs are below q, so one conditional subtract is enough.
	function automatic coeff_t add_mod_q(input coeff_t a, input coeff_t b);
		logic [COEFF_W:0] raw;
		raw = {1'b0, a} + {1'b0, b};
		if (raw >= Q_EXT)
			raw = raw - Q_EXT;
		return raw[COEFF_W-1:0];
	endfunction

	function automatic logic lanes_below_q(input poly_word_t w);
		logic ok;
		ok = 1'b1;
		for (int n = 0; n < LANES; n++) begin
			ok = ok && (w[n] < COEFF_W'(KYBER_Q));
		end
		return ok;
	endfunction

	poly_word_t sum_next;

	always_comb begin
		for (int n = 0; n < LANES; n++) begin
			sum_next[n] = add_mod_q(a_i[n], b_i[n]);
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			sum_valid_o <= 1'b0;
		else
			sum_valid_o <= in_valid_i;
		if (in_valid_i)
			sum_o <= sum_next;
	end

	// The noise side comes out of the RAM and must already be reduced by the sampler.
	a_noise_reduced: assert property (@(posedge clk) disable iff (rst)
		in_valid_i |-> lanes_below_q(b_i))
		else $error("Stored noise coefficient not below q.");

endmodule

//--- design/kyber_noise_acc.sv
`timescale 1ns/1ps

module kyber_noise_acc
	import kyber_params_pkg::*;
	import noise_acc_ctrl_pkg::*;
#(
	parameter int WORDS = WORDS_PER_POLY
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        start_i,
	input  logic        noise_empty_i,
	output logic        noise_req_o,
	input  noise_word_t noise_i,
	input  logic        poly_empty_i,
	output logic        poly_req_o,
	input  poly_word_t  poly_i,
	output poly_word_t  sum_o,
	output logic        sum_valid_o,
	output logic        done_o
);

	logic       cnt_clr;
	logic       cnt_step;
	logic       cnt_last;
	word_idx_t  cnt_idx;

	logic       noise_req_q; // Noise word is on noise_i.
	logic       poly_req_q;  // Poly word and stored noise are both valid.
	word_idx_t  noise_idx_q;

	poly_word_t samp_coeffs;
	logic       samp_wr_en;
	word_idx_t  samp_wr_idx;
	poly_word_t ram_rd_data;

	// ****************************************
	// Control.
	// ****************************************

	noise_acc_fsm u_fsm (
		.clk           (clk),
		.rst           (rst),
		.start_i       (start_i),
		.noise_empty_i (noise_empty_i),
		.poly_empty_i  (poly_empty_i),
		.last_i        (cnt_last),
		.noise_req_o   (noise_req_o),
		.poly_req_o    (poly_req_o),
		.cnt_clr_o     (cnt_clr),
		.cnt_step_o    (cnt_step),
		.done_o        (done_o)
	);

	word_counter #(.COUNT_MAX(WORDS - 1)) u_counter (
		.clk    (clk),
		.rst    (rst),
		.clr_i  (cnt_clr),
		.step_i (cnt_step),
		.idx_o  (cnt_idx),
		.last_o (cnt_last)
	);

	// FIFO data arrives one cycle after the request.
	always_ff @(posedge clk) begin
		if (rst) begin
			noise_req_q <= 1'b0;
			poly_req_q  <= 1'b0;
		end else begin
			noise_req_q <= noise_req_o;
			poly_req_q  <= poly_req_o;
		end
		noise_idx_q <= cnt_idx;
	end

	// ****************************************
	// Datapath.
	// ****************************************

	cbd_sampler u_sampler (
		.clk          (clk),
		.word_valid_i (noise_req_q),
		.word_i       (noise_i),
		.word_idx_i   (noise_idx_q),
		.coeffs_o     (samp_coeffs),
		.wr_en_o      (samp_wr_en),
		.wr_idx_o     (samp_wr_idx)
	);

	poly_ram #(.DEPTH(WORDS)) u_ram (
		.clk       (clk),
		.wr_en_i   (samp_wr_en),
		.wr_idx_i  (samp_wr_idx),
		.wr_data_i (samp_coeffs),
		.rd_idx_i  (cnt_idx),
		.rd_data_o (ram_rd_data)
	);

	mod_q_adder u_adder (
		.clk         (clk),
		.rst         (rst),
		.in_valid_i  (poly_req_q),
		.a_i         (poly_i),
		.b_i         (ram_rd_data),
		.sum_o       (sum_o),
		.sum_valid_o (sum_valid_o)
	);

endmodule

//--- tests/tb_kyber_noise_acc.sv
`timescale 1ns/1ps

module tb_kyber_noise_acc
	import kyber_params_pkg::*;
	import noise_acc_ctrl_pkg::*;
();

	localparam int WAIT_LIMIT = 5000; // Cycles allowed for one run.

	logic        clk = 1'b0;
	logic        rst = 1'b1;
	logic        start = 1'b0;
	logic        noise_empty = 1'b1;
	logic        noise_req;
	noise_word_t noise_word = '0;
	logic        poly_empty = 1'b1;
	logic        poly_req;
	poly_word_t  poly_word = '0;
	poly_word_t  sum;
	logic        sum_valid;
	logic        done;

	logic [15:0] lfsr_state = 16'd57;
	logic        stall_en = 1'b0;
	int          error_count = 0;
	int          tests_run = 0;
	int          tests_failed = 0;

	noise_word_t noise_fifo [$];
	poly_word_t  poly_fifo [$];
	poly_word_t  exp_q [$];
	poly_word_t  got_q [$];
	poly_word_t  prev_q [$];
	noise_word_t noise_mem [WORDS_PER_POLY];
	poly_word_t  poly_mem [WORDS_PER_POLY];

	kyber_noise_acc #(.WORDS(WORDS_PER_POLY)) dut (
		.clk           (clk),
		.rst           (rst),
		.start_i       (start),
		.noise_empty_i (noise_empty),
		.noise_req_o   (noise_req),
		.noise_i       (noise_word),
		.poly_empty_i  (poly_empty),
		.poly_req_o    (poly_req),
		.poly_i        (poly_word),
		.sum_o         (sum),
		.sum_valid_o   (sum_valid),
		.done_o        (done)
	);

	always #4 clk = ~clk;

	// ****************************************
	// Stimulus helpers.
	// ****************************************

	// 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11.
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[15]};
			lfsr_state = lfsr_next(lfsr_state); // One step per bit.
		end
	endtask

	// Both FIFOs answer a request with the front word in the next cycle.
	always @(posedge clk) begin
		logic [31:0] stall_bits;
		stall_bits = '0;
		if (noise_req) begin
			if (noise_empty || noise_fifo.size() == 0) begin
				error_count++;
				$display("Noise request issued while the noise FIFO was empty at %0d ns.", $time);
			end else begin
				noise_word <= noise_fifo.pop_front();
			end
		end
		if (poly_req) begin
			if (poly_empty || poly_fifo.size() == 0) begin
				error_count++;
				$display("Poly request issued while the poly FIFO was empty at %0d ns.", $time);
			end else begin
				poly_word <= poly_fifo.pop_front();
			end
		end
		if (stall_en)
			take_bits(2, stall_bits);
		noise_empty <= noise_fifo.size() == 0 || stall_bits[0];
		poly_empty  <= poly_fifo.size() == 0 || stall_bits[1];
	end

	always @(negedge clk) begin
		if (!rst && sum_valid === 1'b1)
			got_q.push_back(sum);
	end

	// ****************************************
	// Reference model and checks.
	// ****************************************

	function automatic int cbd_ref(input noise_word_t w, input int lane);
		int v;
		v = 0;
		if (w[NOISE_W-1]) begin
			for (int k = 0; k < 3; k++) begin
				v += int'(w[6*lane+k]);
				v -= int'(w[6*lane+3+k]);
			end
		end else begin
			for (int k = 0; k < 2; k++) begin
				v += int'(w[4*lane+k]);
				v -= int'(w[4*lane+2+k]);
			end
		end
		return v;
	endfunction

	function automatic poly_word_t expected_sum(input noise_word_t w, input poly_word_t p);
		poly_word_t r;
		int         nv;
		for (int n = 0; n < LANES; n++) begin
			nv = cbd_ref(w, n);
			if (nv < 0)
				nv += KYBER_Q;
			r[n] = coeff_t'((nv + int'(p[n])) % KYBER_Q);
		end
		return r;
	endfunction

	task automatic compare_word(input string what, input poly_word_t got, input poly_word_t exp);
		if (got !== exp) begin
			error_count++;
			$display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_flag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			error_count++;
			$display("Fail at %0d ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// Eta mode 0 is eta 2, 1 is eta 3, 2 picks one per word.
	// Poly mode 0 is zero, 1 is just below q, 2 is anything below q.
	task automatic make_data(input int eta_mode, input int poly_mode);
		logic [31:0] bits;
		logic [31:0] sel;
		for (int i = 0; i < WORDS_PER_POLY; i++) begin
			take_bits(NOISE_W - 1, bits);
			if (eta_mode == 2)
				take_bits(1, sel);
			else
				sel = 32'(eta_mode);
			noise_mem[i] = {sel[0], bits[NOISE_W-2:0]};
			for (int n = 0; n < LANES; n++) begin
				if (poly_mode == 0) begin
					poly_mem[i][n] = '0;
				end else if (poly_mode == 1) begin
					take_bits(3, bits);
					poly_mem[i][n] = coeff_t'(KYBER_Q - 1 - int'(bits[2:0]));
				end else begin
					take_bits(COEFF_W, bits);
					poly_mem[i][n] = coeff_t'(int'(bits[COEFF_W-1:0]) % KYBER_Q);
				end
			end
		end
	endtask

	task automatic fill_fifos();
		noise_fifo.delete();
		poly_fifo.delete();
		exp_q.delete();
		got_q.delete();
		for (int i = 0; i < WORDS_PER_POLY; i++) begin
			noise_fifo.push_back(noise_mem[i]);
			poly_fifo.push_back(poly_mem[i]);
			exp_q.push_back(expected_sum(noise_mem[i], poly_mem[i]));
		end
	endtask

	task automatic start_run();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		compare_flag("done_o after start", done, 1'b0);
	endtask

	task automatic wait_done(input string what);
		int cycles;
		cycles = 0;
		while (done !== 1'b1 && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (done !== 1'b1) begin
			error_count++;
			$display("Timeout: done_o never rose during the %s.", what);
		end
	endtask

	task automatic check_sums(input string what);
		if (got_q.size() != exp_q.size()) begin
			error_count++;
			$display("Fail at %0d ns: %s gave %0d sum words, expected %0d", $time, what,
				got_q.size(), exp_q.size());
		end
		for (int i = 0; i < exp_q.size() && i < got_q.size(); i++)
			compare_word($sformatf("%s sum word %0d", what, i), got_q[i], exp_q[i]);
	endtask

	task automatic run_once(input string what);
		fill_fifos();
		start_run();
		wait_done(what);
		check_sums(what);
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (error_count == errors_before) begin
			$display("%s: passed", name);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, error_count - errors_before);
		end
	endtask

	// ****************************************
	// Directed tests.
	// ****************************************

	task automatic test_reset();
		int errors_before;
		errors_before = error_count;
		for (int i = 0; i <= 20; i++) begin
			@(negedge clk);
			compare_flag("noise_req_o while idle", noise_req, 1'b0);
			compare_flag("poly_req_o while idle", poly_req, 1'b0);
			compare_flag("sum_valid_o while idle", sum_valid, 1'b0);
			compare_flag("done_o while idle", done, 1'b0);
		end
		finish_test("test_reset", errors_before);
	endtask

	task automatic test_eta2_zero_poly();
		int errors_before;
		errors_before = error_count;
		make_data(0, 0);
		run_once("eta 2 run");
		finish_test("test_eta2_zero_poly", errors_before);
	endtask

	task automatic test_eta3_wrap();
		int errors_before;
		errors_before = error_count;
		make_data(1, 1);
		run_once("eta 3 wrap run");
		finish_test("test_eta3_wrap", errors_before);
	endtask

	task automatic test_stalls();
		int errors_before;
		errors_before = error_count;
		make_data(2, 2);
		run_once("unstalled run");
		prev_q = got_q;
		stall_en = 1'b1; // Both FIFOs now go empty at random.
		run_once("stalled run");
		stall_en = 1'b0;
		for (int i = 0; i < prev_q.size() && i < got_q.size(); i++)
			compare_word($sformatf("stalled against unstalled word %0d", i), got_q[i], prev_q[i]);
		finish_test("test_stalls", errors_before);
	endtask

	task automatic test_restart();
		int errors_before;
		errors_before = error_count;
		compare_flag("done_o before restart", done, 1'b1);
		make_data(2, 1);
		run_once("restart run");
		finish_test("test_restart", errors_before);
	endtask

	initial begin
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		test_reset();
		test_eta2_zero_poly();
		test_eta3_wrap();
		test_stalls();
		test_restart();
		$display("Tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed,
			error_count);
		if (error_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

//--- kyber_noise_acc.f
design/kyber_params_pkg.sv
design/noise_acc_ctrl_pkg.sv
design/noise_acc_fsm.sv
design/word_counter.sv
design/cbd_sampler.sv
design/poly_ram.sv
design/mod_q_adder.sv
design/kyber_noise_acc.sv
tests/tb_kyber_noise_acc.sv

//--- Makefile
# Verilator build and run for the Kyber noise accumulator.

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

# The run passes only if the pass message shows up in the output.
test:
	verilator --binary --timing --assert -Wno-fatal -f kyber_noise_acc.f \
		--top-module tb_kyber_noise_acc -Mdir obj_dir -o sim
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir
